//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decoder
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST OK

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when the file list or a source is newer than the binary
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
src/graph_pkg.sv
src/stage_pkg.sv
src/link_if.sv
src/stage_controller.sv
src/round_timer.sv
src/processing_unit.sv
src/neighbor_link.sv
src/decoding_graph.sv
src/decoder_top.sv
tests/decoder_chk.sv
tests/tb_decoder.sv

//--- src/decoder_top.sv
`timescale 1ns/10ps
`default_nettype none

module decoder_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start,
    input  stage_pkg::round_count_t                       grow_rounds,
    input  graph_pkg::pu_vec_t                            measurements,
    output graph_pkg::address_t [graph_pkg::pu_count-1:0] roots,
    output graph_pkg::pu_vec_t                            touched,
    output graph_pkg::link_vec_t                          fully_grown,
    output logic                                          busy,
    output logic                                          done
);

    logic load_en;
    logic grow_en;
    logic merge_en;
    logic timer_clear;
    logic round_step;
    logic merge_last;
    logic rounds_reached;

    stage_controller u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .grow_rounds   (grow_rounds),
        .merge_last    (merge_last),
        .rounds_reached(rounds_reached),
        .load_en       (load_en),
        .grow_en       (grow_en),
        .merge_en      (merge_en),
        .timer_clear   (timer_clear),
        .round_step    (round_step),
        .busy          (busy),
        .done          (done)
    );

    round_timer u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_clear   (timer_clear),
        .merge_en      (merge_en),
        .round_step    (round_step),
        .grow_rounds   (grow_rounds),
        .merge_last    (merge_last),
        .rounds_reached(rounds_reached)
    );

    decoding_graph u_graph (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .grow_en     (grow_en),
        .merge_en    (merge_en),
        .measurements(measurements),
        .roots       (roots),
        .touched     (touched),
        .fully_grown (fully_grown)
    );

endmodule

`default_nettype wire

//--- src/decoding_graph.sv
`timescale 1ns/10ps
`default_nettype none

module decoding_graph (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        load_en,
    input  logic                                        grow_en,
    input  logic                                        merge_en,
    input  graph_pkg::pu_vec_t                          measurements,
    output graph_pkg::address_t [graph_pkg::pu_count-1:0] roots,
    output graph_pkg::pu_vec_t                          touched,
    output graph_pkg::link_vec_t                        fully_grown
);
    import graph_pkg::*;

    localparam int dx = code_distance_x;
    localparam int dz = code_distance_z;
    localparam int dm = measurement_rounds;

    link_if ns_if [ns_link_count] ();
    link_if ew_if [ew_link_count] ();
    link_if ud_if [ud_link_count] ();

    // ==================================================
    // processing units
    // ==================================================

    for (genvar k = 0; k < dm; k++) begin : g_round
        for (genvar i = 0; i < dx; i++) begin : g_row
            for (genvar j = 0; j < dz; j++) begin : g_col
                localparam int pu = i * dz + j + k * dx * dz;
                // a boundary side borrows the opposite link of the same direction
                localparam int north_idx = k * (dx - 1) * dz + ((i > 0) ? i - 1 : i) * dz + j;
                localparam int south_idx = k * (dx - 1) * dz + ((i < dx - 1) ? i : i - 1) * dz + j;
                localparam int west_idx = k * dx * (dz - 1) + i * (dz - 1) + ((j > 0) ? j - 1 : j);
                localparam int east_idx = k * dx * (dz - 1) + i * (dz - 1) + ((j < dz - 1) ? j : j - 1);
                localparam int down_idx = ((k > 0) ? k - 1 : k) * dx * dz + i * dz + j;
                localparam int up_idx = ((k < dm - 1) ? k : k - 1) * dx * dz + i * dz + j;

                processing_unit #(
                    .address(address_t'((k << (2 * per_dim_width)) + (i << per_dim_width) + j)),
                    .neighbor_mask({k < dm - 1, k > 0, j < dz - 1, j > 0, i < dx - 1, i > 0})
                ) u_pu (
                    .clk        (clk),
                    .rst_n      (rst_n),
                    .load_en    (load_en),
                    .merge_en   (merge_en),
                    .measurement(measurements[pu]),
                    .north      (ns_if[north_idx]),
                    .south      (ns_if[south_idx]),
                    .west       (ew_if[west_idx]),
                    .east       (ew_if[east_idx]),
                    .down       (ud_if[down_idx]),
                    .up         (ud_if[up_idx]),
                    .root       (roots[pu]),
                    .touched    (touched[pu])
                );
            end
        end
    end

    // ==================================================
    // links, north-south then east-west then up-down
    // ==================================================

    for (genvar n = 0; n < ns_link_count; n++) begin : g_ns
        neighbor_link #(.weight(weight_x)) u_link (
            .clk(clk), .rst_n(rst_n), .load_en(load_en), .grow_en(grow_en), .conn(ns_if[n])
        );
        assign fully_grown[n] = ns_if[n].fully_grown;
    end

    for (genvar n = 0; n < ew_link_count; n++) begin : g_ew
        neighbor_link #(.weight(weight_z)) u_link (
            .clk(clk), .rst_n(rst_n), .load_en(load_en), .grow_en(grow_en), .conn(ew_if[n])
        );
        assign fully_grown[ns_link_count + n] = ew_if[n].fully_grown;
    end

    for (genvar n = 0; n < ud_link_count; n++) begin : g_ud
        neighbor_link #(.weight(weight_m)) u_link (
            .clk(clk), .rst_n(rst_n), .load_en(load_en), .grow_en(grow_en), .conn(ud_if[n])
        );
        assign fully_grown[ns_link_count + ew_link_count + n] = ud_if[n].fully_grown;
    end

endmodule

`default_nettype wire

//--- src/graph_pkg.sv
`default_nettype none

package graph_pkg;

    // ==================================================
    // graph geometry
    // ==================================================

    localparam int code_distance_x = 3;
    localparam int code_distance_z = 2;
    localparam int measurement_rounds =
        (code_distance_x > code_distance_z) ? code_distance_x : code_distance_z;
    localparam int per_dim_width = $clog2(measurement_rounds);
    localparam int address_width = 3 * per_dim_width;

    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds;

    // boundary sides carry no link, so each direction loses one layer
    localparam int ns_link_count = (code_distance_x - 1) * code_distance_z * measurement_rounds;
    localparam int ew_link_count = code_distance_x * (code_distance_z - 1) * measurement_rounds;
    localparam int ud_link_count = code_distance_x * code_distance_z * (measurement_rounds - 1);
    localparam int link_count = ns_link_count + ew_link_count + ud_link_count;

    // growth needed to fill a north-south, east-west or up-down link
    localparam int weight_x = 2;
    localparam int weight_z = 2;
    localparam int weight_m = 2;

    // ==================================================
    // types
    // ==================================================

    // round, row, column from msb to lsb
    typedef logic [address_width-1:0] address_t;
    typedef logic [1:0]               growth_t;
    typedef logic [pu_count-1:0]      pu_vec_t;
    typedef logic [link_count-1:0]    link_vec_t;

endpackage

`default_nettype wire

//--- src/link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface link_if;
    import graph_pkg::*;

    // end a is the lower-indexed unit of the pair
    address_t a_root;
    logic     a_touched;
    address_t b_root;
    logic     b_touched;
    logic     fully_grown;

    modport end_a (
        output a_root, a_touched,
        input  b_root, b_touched, fully_grown
    );

    modport end_b (
        output b_root, b_touched,
        input  a_root, a_touched, fully_grown
    );

    modport link (
        input  a_touched, b_touched,
        output fully_grown
    );

endinterface

`default_nettype wire

//--- src/neighbor_link.sv
`timescale 1ns/10ps
`default_nettype none

module neighbor_link #(
    parameter int weight = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_en,
    input  logic  grow_en,
    link_if.link  conn
);
    import graph_pkg::*;

    growth_t    growth;
    logic [2:0] grown_sum;

    // each touched end adds one unit of growth per grow cycle
    assign grown_sum = 3'(growth) + 3'(conn.a_touched) + 3'(conn.b_touched);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            growth <= '0;
        end else if (load_en) begin
            growth <= '0;
        end else if (grow_en) begin
            if (grown_sum >= 3'(weight)) begin
                growth <= growth_t'(weight);
            end else begin
                growth <= growth_t'(grown_sum);
            end
        end
    end

    assign conn.fully_grown = (growth == growth_t'(weight));

endmodule

`default_nettype wire

//--- src/processing_unit.sv
`timescale 1ns/10ps
`default_nettype none

module processing_unit #(
    parameter graph_pkg::address_t address       = '0,
    parameter logic [5:0]          neighbor_mask = 6'b111111
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_en,
    input  logic                merge_en,
    input  logic                measurement,
    link_if.end_b               north,
    link_if.end_a               south,
    link_if.end_b               west,
    link_if.end_a               east,
    link_if.end_b               down,
    link_if.end_a               up,
    output graph_pkg::address_t root,
    output logic                touched
);
    import graph_pkg::*;

    // direction order is north, south, west, east, down, up from bit 0
    address_t   nb_root [6];
    logic [5:0] nb_touched;
    logic [5:0] nb_grown;
    address_t   min_root;
    logic       any_touched;

    assign nb_root = '{north.a_root, south.b_root, west.a_root,
                       east.b_root, down.a_root, up.b_root};
    assign nb_touched = {up.b_touched, down.a_touched, east.b_touched,
                         west.a_touched, south.b_touched, north.a_touched};
    assign nb_grown = neighbor_mask & {up.fully_grown, down.fully_grown, east.fully_grown,
                                       west.fully_grown, south.fully_grown, north.fully_grown};

    always_comb begin
        min_root    = root;
        any_touched = touched;
        for (int d = 0; d < 6; d++) begin
            if (nb_grown[d]) begin
                any_touched = any_touched | nb_touched[d];
                if (nb_root[d] < min_root) begin
                    min_root = nb_root[d];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            root    <= '0;
            touched <= 1'b0;
        end else if (load_en) begin
            root    <= address;
            touched <= measurement;
        end else if (merge_en) begin
            root    <= min_root;
            touched <= any_touched;
        end
    end

    // a missing side is tied to another unit's link, so only present sides drive
    if (neighbor_mask[0]) begin : g_north
        assign north.b_root    = root;
        assign north.b_touched = touched;
    end
    if (neighbor_mask[1]) begin : g_south
        assign south.a_root    = root;
        assign south.a_touched = touched;
    end
    if (neighbor_mask[2]) begin : g_west
        assign west.b_root    = root;
        assign west.b_touched = touched;
    end
    if (neighbor_mask[3]) begin : g_east
        assign east.a_root    = root;
        assign east.a_touched = touched;
    end
    if (neighbor_mask[4]) begin : g_down
        assign down.b_root    = root;
        assign down.b_touched = touched;
    end
    if (neighbor_mask[5]) begin : g_up
        assign up.a_root    = root;
        assign up.a_touched = touched;
    end

endmodule

`default_nettype wire

//--- src/round_timer.sv
`timescale 1ns/10ps
`default_nettype none

module round_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    timer_clear,
    input  logic                    merge_en,
    input  logic                    round_step,
    input  stage_pkg::round_count_t grow_rounds,
    output logic                    merge_last,
    output logic                    rounds_reached
);
    import stage_pkg::*;

    merge_count_t merge_cnt;
    round_count_t rounds_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            merge_cnt   <= '0;
            rounds_done <= '0;
        end else if (timer_clear) begin
            merge_cnt   <= '0;
            rounds_done <= '0;
        end else begin
            if (merge_en) begin
                merge_cnt <= merge_last ? '0 : merge_cnt + 1'b1;
            end
            if (round_step) begin
                rounds_done <= rounds_done + 1'b1;
            end
        end
    end

    assign merge_last = (merge_cnt == merge_count_t'(merge_cycles - 1));

    // looks ahead to the round that closes with this merge
    assign rounds_reached = (({1'b0, rounds_done} + 4'd1) == {1'b0, grow_rounds});

endmodule

`default_nettype wire

//--- src/stage_controller.sv
`timescale 1ns/10ps
`default_nettype none

module stage_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  stage_pkg::round_count_t grow_rounds,
    input  logic                    merge_last,
    input  logic                    rounds_reached,
    output logic                    load_en,
    output logic                    grow_en,
    output logic                    merge_en,
    output logic                    timer_clear,
    output logic                    round_step,
    output logic                    busy,
    output logic                    done
);
    import stage_pkg::*;

    decode_state_e state;
    decode_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:  if (start) next_state = st_load;
            st_load:  next_state = (grow_rounds == '0) ? st_done : st_grow;
            st_grow:  next_state = st_merge;
            st_merge: begin
                if (merge_last) begin
                    next_state = rounds_reached ? st_done : st_grow;
                end
            end
            default:  next_state = st_idle;
        endcase
    end

    // strobes decode straight from the state, so each lasts one state
    assign load_en     = (state == st_load);
    assign grow_en     = (state == st_grow);
    assign merge_en    = (state == st_merge);
    assign timer_clear = (state == st_load);
    assign round_step  = (state == st_merge) && merge_last;
    assign busy        = load_en || grow_en || merge_en;
    assign done        = (state == st_done);

endmodule

`default_nettype wire

//--- src/stage_pkg.sv
`default_nettype none

package stage_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_grow,
        st_merge,
        st_done
    } decode_state_e;

    typedef logic [2:0] round_count_t;

    // one merge cycle per unit always covers the graph diameter
    localparam int merge_cycles = graph_pkg::pu_count;

    typedef logic [$clog2(merge_cycles)-1:0] merge_count_t;

endpackage

`default_nettype wire

//--- tests/decoder_chk.sv
`timescale 1ns/10ps
`default_nettype none

module decoder_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 load_en,
    input logic                 busy,
    input logic                 done,
    input graph_pkg::link_vec_t fully_grown
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high in the same cycle");

    // the load cycle clears every counter, so growth is only monotonic after it
    growth_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !load_en |=> (($past(fully_grown) & ~fully_grown) == '0))
        else $error("a grown link dropped during a decode");

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else $error("busy high right after reset release");

endmodule

bind decoder_top decoder_chk i_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .busy       (busy),
    .done       (done),
    .fully_grown(fully_grown)
);

`default_nettype wire

//--- tests/tb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decoder;
    import graph_pkg::*;
    import stage_pkg::*;

    localparam int dx = code_distance_x;
    localparam int dz = code_distance_z;
    localparam int timeout_cycles = 200;

    typedef address_t [pu_count-1:0] root_vec_t;

    typedef struct packed {
        root_vec_t roots;
        pu_vec_t   touched;
        link_vec_t grown;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         start;
    round_count_t grow_rounds;
    pu_vec_t      measurements;
    root_vec_t    roots;
    pu_vec_t      touched;
    link_vec_t    fully_grown;
    logic         busy;
    logic         done;

    integer  seed;
    integer  rnd;
    expect_t exp_result;
    int      exp_latency;
    int      start_count;
    int      cycle_count;
    int      busy_count;
    int      busy_start;
    int      checks_done;
    int      test_errors;
    int      error_count;
    int      test_count;
    int      failed_tests;
    bit      timed_out;
    string   test_name;

    decoder_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .grow_rounds (grow_rounds),
        .measurements(measurements),
        .roots       (roots),
        .touched     (touched),
        .fully_grown (fully_grown),
        .busy        (busy),
        .done        (done)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        cycle_count <= cycle_count + 1;
        if (busy) begin
            busy_count <= busy_count + 1;
        end
    end

    // ==================================================
    // reference model
    // ==================================================

    function automatic address_t unit_address(input int p);
        int k;
        int i;
        int j;
        k = p / (dx * dz);
        i = (p % (dx * dz)) / dz;
        j = p % dz;
        return address_t'((k << (2 * per_dim_width)) | (i << per_dim_width) | j);
    endfunction

    // links are listed north-south, then east-west, then up-down
    function automatic void link_ends(input int l, output int a, output int b);
        int r;
        int k;
        int i;
        int j;
        if (l < ns_link_count) begin
            k = l / ((dx - 1) * dz);
            r = l % ((dx - 1) * dz);
            a = k * dx * dz + (r / dz) * dz + r % dz;
            b = a + dz;
        end else if (l < ns_link_count + ew_link_count) begin
            r = l - ns_link_count;
            k = r / (dx * (dz - 1));
            i = (r % (dx * (dz - 1))) / (dz - 1);
            j = r % (dz - 1);
            a = k * dx * dz + i * dz + j;
            b = a + 1;
        end else begin
            a = l - ns_link_count - ew_link_count;
            b = a + dx * dz;
        end
    endfunction

    function automatic int link_weight(input int l);
        if (l < ns_link_count) return weight_x;
        if (l < ns_link_count + ew_link_count) return weight_z;
        return weight_m;
    endfunction

    function automatic expect_t reference_decode(input pu_vec_t meas, input int rounds);
        expect_t   res;
        int        growth [link_count];
        root_vec_t root;
        root_vec_t nroot;
        pu_vec_t   tch;
        pu_vec_t   ntch;
        int        a;
        int        b;
        bit        changed;
        for (int p = 0; p < pu_count; p++) root[p] = unit_address(p);
        tch = meas;
        for (int l = 0; l < link_count; l++) growth[l] = 0;
        for (int r = 0; r < rounds; r++) begin
            for (int l = 0; l < link_count; l++) begin
                link_ends(l, a, b);
                growth[l] = growth[l] + int'(tch[a]) + int'(tch[b]);
                if (growth[l] > link_weight(l)) growth[l] = link_weight(l);
            end
            // spread minimum root and touched over grown links until nothing changes
            changed = 1'b1;
            while (changed) begin
                nroot = root;
                ntch  = tch;
                for (int l = 0; l < link_count; l++) begin
                    if (growth[l] == link_weight(l)) begin
                        link_ends(l, a, b);
                        if (root[b] < nroot[a]) nroot[a] = root[b];
                        if (root[a] < nroot[b]) nroot[b] = root[a];
                        ntch[a] = ntch[a] | tch[b];
                        ntch[b] = ntch[b] | tch[a];
                    end
                end
                changed = (nroot != root) || (ntch != tch);
                root = nroot;
                tch  = ntch;
            end
        end
        res.roots   = root;
        res.touched = tch;
        for (int l = 0; l < link_count; l++) res.grown[l] = (growth[l] == link_weight(l));
        return res;
    endfunction

    // ==================================================
    // comparison
    // ==================================================

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    always @(negedge clk) begin
        if (done) begin
            assert (roots == exp_result.roots)
                else report_mismatch("roots", 128'(exp_result.roots), 128'(roots));
            assert (touched == exp_result.touched)
                else report_mismatch("touched", 128'(exp_result.touched), 128'(touched));
            assert (fully_grown == exp_result.grown)
                else report_mismatch("fully_grown", 128'(exp_result.grown), 128'(fully_grown));
            assert (cycle_count - start_count == exp_latency)
                else report_mismatch("latency", 128'(exp_latency), 128'(cycle_count - start_count));
            // busy covers every cycle from load up to the one before done
            assert (busy_count - busy_start == exp_latency - 1)
                else report_mismatch("busy_cycles", 128'(exp_latency - 1),
                                     128'(busy_count - busy_start));
            checks_done++;
        end
    end

    // ==================================================
    // stimulus
    // ==================================================

    task automatic run_decode(input string name, input pu_vec_t meas, input int rounds,
                              input bit restart_while_busy);
        int seen;
        int waited;
        // once a decode hangs, the remaining tests are skipped
        if (timed_out) return;
        test_name   = name;
        exp_result  = reference_decode(meas, rounds);
        exp_latency = 2 + rounds * (merge_cycles + 1);
        test_errors = 0;
        seen        = checks_done;
        @(posedge clk);
        start_count = cycle_count;
        busy_start  = busy_count;
        start        <= 1'b1;
        measurements <= meas;
        grow_rounds  <= round_count_t'(rounds);
        @(posedge clk);
        start <= 1'b0;
        if (restart_while_busy) begin
            repeat (6) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        waited = 0;
        while (checks_done == seen && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (checks_done == seen) begin
            $display("no done pulse in test %s within %0d cycles", name, timeout_cycles);
            timed_out = 1'b1;
            test_count++;
            failed_tests++;
            error_count++;
        end else begin
            if (restart_while_busy) begin
                repeat (3) @(negedge clk);
                assert (!busy && !done) else begin
                    $display("test %s started a second decode after done", name);
                    test_errors++;
                    error_count++;
                end
            end
            test_count++;
            if (test_errors != 0) failed_tests++;
            $display("test %s: %s", name, (test_errors == 0) ? "pass" : "fail");
        end
    endtask

    initial begin
        seed         = 32'h3496120b;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        grow_rounds  = '0;
        measurements = '0;
        cycle_count  = 0;
        busy_count   = 0;
        busy_start   = 0;
        checks_done  = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        test_errors  = 0;
        timed_out    = 1'b0;
        exp_result   = '0;
        exp_latency  = 0;
        start_count  = 0;
        test_name    = "";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_decode("all_zero", '0, 3, 1'b0);
        run_decode("single_defect_r1", pu_vec_t'(1) << 8, 1, 1'b0);
        run_decode("single_defect_r2", pu_vec_t'(1) << 8, 2, 1'b0);
        // units 8 and 9 share an east-west link
        run_decode("adjacent_pair_r1", pu_vec_t'(3) << 8, 1, 1'b0);
        run_decode("zero_rounds", pu_vec_t'(18'h2a5c3), 0, 1'b0);
        for (int n = 0; n < 10; n++) begin
            pu_vec_t meas;
            rnd  = $random(seed);
            meas = rnd[pu_count-1:0];
            rnd  = $random(seed);
            run_decode($sformatf("random_%0d", n), meas, int'(rnd[2:0]), 1'b0);
        end
        rnd = $random(seed);
        run_decode("start_while_busy", rnd[pu_count-1:0], 2, 1'b1);

        $display("tests run %0d, failing tests %0d, failed checks %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
